/* tb.f */
+incdir+sim
src/decode_pkg.sv
src/decode_imm_forms.sv
src/decode_reg_forms.sv
src/decode_format_mux.sv
src/decode_unit.sv
sim/tb_decode.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP := tb_decode
FILELIST := tb.f

OBJ_DIR := obj_dir
LOG := sim.log
SOURCES := $(wildcard src/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides, the simulator exit code alone is not trusted
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_decode_ref.svh */
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

`default_nettype none

////////////////////////////////////////
// instruction encoders, isa bit order
////////////////////////////////////////
function automatic logic [31:0] d_word(input logic [5:0] op, input logic [4:0] rt,
	input logic [4:0] ra, input logic [15:0] d);
	return {op, rt, ra, d};
endfunction

function automatic logic [31:0] dq_word(input logic [4:0] rt, input logic [4:0] ra,
	input logic [11:0] dq, input logic [3:0] low);
	return {decode_pkg::op_lq, rt, ra, dq, low};
endfunction

function automatic logic [31:0] ds_word(input logic [5:0] op, input logic [4:0] rt,
	input logic [4:0] ra, input logic [13:0] ds, input logic [1:0] xo);
	return {op, rt, ra, ds, xo};
endfunction

function automatic logic [31:0] x_word(input logic [4:0] rt, input logic [4:0] ra,
	input logic [4:0] rb, input logic [9:0] xo, input logic rc);
	return {decode_pkg::op_ext, rt, ra, rb, xo, rc};
endfunction

function automatic logic [31:0] xo_word(input logic [4:0] rt, input logic [4:0] ra,
	input logic [4:0] rb, input logic oe, input logic [8:0] xo, input logic rc);
	return {decode_pkg::op_ext, rt, ra, rb, oe, xo, rc};
endfunction

// sh is split, low five bits up front and the top bit near rc
function automatic logic [31:0] md_word(input logic [4:0] rs, input logic [4:0] ra,
	input logic [5:0] sh, input logic [5:0] mb, input logic [2:0] xo, input logic rc);
	return {decode_pkg::op_md, rs, ra, sh[4:0], mb, xo, sh[5], rc};
endfunction

// two registers plus immediate, rt written and ra read
function automatic decode_pkg::decoded_t imm_form_regs(input decode_pkg::decoded_t e,
	input logic [4:0] r1, input logic [4:0] r2);
	e.reg1 = r1;
	e.reg2 = r2;
	e.reg1_use = decode_pkg::reg_write;
	e.reg2_use = decode_pkg::reg_read;
	e.reg1_en = 1'b1;
	e.reg2_en = 1'b1;
	e.imm_en = 1'b1;
	return e;
endfunction

function automatic decode_pkg::decoded_t reg_form_regs(input decode_pkg::decoded_t e,
	input logic [4:0] r1, input logic [4:0] r2, input logic [4:0] r3);
	e.reg1 = r1;
	e.reg2 = r2;
	e.reg3 = r3;
	e.reg1_use = decode_pkg::reg_write;
	e.reg2_use = decode_pkg::reg_read;
	e.reg3_use = decode_pkg::reg_read;
	e.reg1_en = 1'b1;
	e.reg2_en = 1'b1;
	e.reg3_en = 1'b1;
	return e;
endfunction

////////////////////////////////////////
// expected decoded bus for one fetch
////////////////////////////////////////
function automatic decode_pkg::decoded_t decode_ref(input decode_pkg::fetch_t f);
	decode_pkg::decoded_t e;
	logic [31:0] w;
	logic [5:0] op;
	logic [8:0] xo9;
	logic [63:0] d_sext;
	w = f.instr.raw;
	op = w[31:26];
	xo9 = w[9:1];
	d_sext = {{48{w[15]}}, w[15:0]};
	e = '0;
	e.valid = f.valid;
	e.address = f.address;
	e.opcode = op;
	e.format = decode_pkg::fmt_invalid;
	e.fu = decode_pkg::fu_none;
	case (op)
		decode_pkg::op_addi, decode_pkg::op_addis, decode_pkg::op_ori, decode_pkg::op_lwz:
		begin
			e = imm_form_regs(e, w[25:21], w[20:16]);
			e.format = decode_pkg::fmt_d;
			e.fu = decode_pkg::fu_alu;
			e.ra_or_zero = 1'b1;
			e.imm = d_sext;
			if (op == decode_pkg::op_addis)
				e.imm = d_sext << 16;
			if (op == decode_pkg::op_lwz)
				e.fu = decode_pkg::fu_ldst;
			if (op == decode_pkg::op_ori)
			begin
				// logical immediate, ra is the target
				e.fu = decode_pkg::fu_logic;
				e.ra_or_zero = 1'b0;
				e.reg1 = w[20:16];
				e.reg2 = w[25:21];
				e.imm = {48'b0, w[15:0]};
			end
		end
		decode_pkg::op_lq:
		begin
			e = imm_form_regs(e, w[25:21], w[20:16]);
			e.format = decode_pkg::fmt_dq;
			e.fu = decode_pkg::fu_ldst;
			e.ra_or_zero = 1'b1;
			e.imm = {{48{w[15]}}, w[15:4], 4'b0000};
			e.bit1 = w[0];
			e.bit1_en = 1'b1;
		end
		decode_pkg::op_ds_ld, decode_pkg::op_ds_std:
		begin
			if (w[1:0] == 2'b00)
			begin
				e = imm_form_regs(e, w[25:21], w[20:16]);
				e.format = decode_pkg::fmt_ds;
				e.fu = decode_pkg::fu_ldst;
				e.imm = {{48{w[15]}}, w[15:2], 2'b00};
				if (op == decode_pkg::op_ds_ld)
					e.ra_or_zero = 1'b1;
				else
					e.reg1_use = decode_pkg::reg_read;
			end
		end
		decode_pkg::op_ext:
		begin
			e = reg_form_regs(e, w[25:21], w[20:16], w[15:11]);
			e.bit1_en = 1'b1;
			e.xopcode_en = 1'b1;
			if (xo9 == decode_pkg::xo_add || xo9 == decode_pkg::xo_subf
				|| xo9 == decode_pkg::xo_mullw || xo9 == decode_pkg::xo_divw)
			begin
				e.format = decode_pkg::fmt_xo;
				e.xopcode = {1'b0, xo9};
				e.bit1 = w[10];
				e.bit2 = w[0];
				e.bit2_en = 1'b1;
				e.fu = decode_pkg::fu_alu;
				if (xo9 == decode_pkg::xo_mullw)
					e.fu = decode_pkg::fu_mul;
				if (xo9 == decode_pkg::xo_divw)
					e.fu = decode_pkg::fu_div;
			end
			else
			begin
				e.format = decode_pkg::fmt_x;
				e.xopcode = w[10:1];
				e.bit1 = w[0];
				e.fu = decode_pkg::fu_logic;
			end
		end
		decode_pkg::op_md:
		begin
			e = reg_form_regs(e, w[25:21], w[20:16], w[15:11]);
			e.format = decode_pkg::fmt_md;
			e.fu = decode_pkg::fu_alu;
			e.reg1_use = decode_pkg::reg_read;
			e.reg2_use = decode_pkg::reg_write;
			e.reg3_use = decode_pkg::reg_unused;
			e.reg3_is_imm = 1'b1;
			e.imm = {58'b0, w[1], w[15:11]};
			e.imm_en = 1'b1;
			e.bit1 = w[0];
			e.bit1_en = 1'b1;
			e.bit2 = w[1];
			e.bit2_en = 1'b1;
		end
		default:
		begin
			e.format = decode_pkg::fmt_invalid;
		end
	endcase
	return e;
endfunction

`default_nettype wire

`endif

/* sim/tb_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode;

	localparam int reset_cycles = 16;
	localparam int n_idle = 8;
	localparam int n_d = 24;
	localparam int n_mem = 24;
	localparam int n_ext = 32;
	localparam int n_md = 16;
	localparam int n_mix = 64;
	localparam int total_slots = n_idle + n_d + n_mem + n_ext + n_md + n_mix;
	localparam int timeout_limit = total_slots + reset_cycles + 50;
	// stream kind that picks a random format per slot
	localparam int kind_mixed = 5;

	logic clock_i;
	logic arst_n_i;
	decode_pkg::fetch_t fetch_i;
	decode_pkg::decoded_t decoded_o;

	// expected results and the cycle each input was driven
	decode_pkg::decoded_t exp_q[$];
	int stamp_q[$];
	decode_pkg::decoded_t exp_head;
	int stamp_head;
	int cycle_count;
	int error_count;
	int check_count;

	`include "tb_decode_ref.svh"

	decode_unit uut (
		.clock_i (clock_i),
		.arst_n_i (arst_n_i),
		.fetch_i (fetch_i),
		.decoded_o (decoded_o)
	);

	always #2 clock_i = ~clock_i;

	always @(posedge clock_i)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit)
		begin
			$display("timeout at cycle %0d, %0d instructions never came out",
				cycle_count, exp_q.size());
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic compare_field(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count = check_count + 1;
		if (expected !== actual)
		begin
			$display("Fail %s expected 0x%0h got 0x%0h", name, expected, actual);
			error_count = error_count + 1;
		end
	endtask

	task automatic check_format(input decode_pkg::format_e expected,
		input decode_pkg::format_e actual);
		check_count = check_count + 1;
		if (expected !== actual)
		begin
			$display("Fail format expected 0x%0h got 0x%0h", expected, actual);
			error_count = error_count + 1;
		end
	endtask

	task automatic check_imm(input logic [63:0] expected, input logic [63:0] actual);
		check_count = check_count + 1;
		if (expected !== actual)
		begin
			$display("Fail imm expected 0x%0h got 0x%0h", expected, actual);
			error_count = error_count + 1;
		end
	endtask

	task automatic check_decoded(input decode_pkg::decoded_t expected,
		input decode_pkg::decoded_t actual);
		compare_field("valid", 64'(expected.valid), 64'(actual.valid));
		compare_field("address", expected.address, actual.address);
		compare_field("opcode", 64'(expected.opcode), 64'(actual.opcode));
		check_format(expected.format, actual.format);
		check_imm(expected.imm, actual.imm);
		compare_field("imm_en", 64'(expected.imm_en), 64'(actual.imm_en));
		compare_field("reg1", 64'(expected.reg1), 64'(actual.reg1));
		compare_field("reg2", 64'(expected.reg2), 64'(actual.reg2));
		compare_field("reg3", 64'(expected.reg3), 64'(actual.reg3));
		compare_field("reg1_use", 64'(expected.reg1_use), 64'(actual.reg1_use));
		compare_field("reg2_use", 64'(expected.reg2_use), 64'(actual.reg2_use));
		compare_field("reg3_use", 64'(expected.reg3_use), 64'(actual.reg3_use));
		compare_field("reg1_en", 64'(expected.reg1_en), 64'(actual.reg1_en));
		compare_field("reg2_en", 64'(expected.reg2_en), 64'(actual.reg2_en));
		compare_field("reg3_en", 64'(expected.reg3_en), 64'(actual.reg3_en));
		compare_field("reg3_is_imm", 64'(expected.reg3_is_imm), 64'(actual.reg3_is_imm));
		compare_field("bit1", 64'(expected.bit1), 64'(actual.bit1));
		compare_field("bit2", 64'(expected.bit2), 64'(actual.bit2));
		compare_field("bit1_en", 64'(expected.bit1_en), 64'(actual.bit1_en));
		compare_field("bit2_en", 64'(expected.bit2_en), 64'(actual.bit2_en));
		compare_field("ra_or_zero", 64'(expected.ra_or_zero), 64'(actual.ra_or_zero));
		compare_field("xopcode", 64'(expected.xopcode), 64'(actual.xopcode));
		compare_field("xopcode_en", 64'(expected.xopcode_en), 64'(actual.xopcode_en));
		compare_field("fu", 64'(expected.fu), 64'(actual.fu));
	endtask

	// outputs are stable on the falling edge, stamps give the exact latency
	always @(negedge clock_i)
	begin
		if (decoded_o.valid === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				$display("output valid at cycle %0d with no instruction in flight", cycle_count);
				error_count = error_count + 1;
			end
			else
			begin
				exp_head = exp_q.pop_front();
				stamp_head = stamp_q.pop_front();
				if (cycle_count != stamp_head + 2)
				begin
					$display("output at cycle %0d belongs to input of cycle %0d, wrong latency",
						cycle_count, stamp_head);
					error_count = error_count + 1;
				end
				check_decoded(exp_head, decoded_o);
			end
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	function automatic logic [31:0] random_word(input int kind);
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] w;
		logic [5:0] op;
		logic [8:0] xo9;
		int sel;
		r1 = $urandom;
		r2 = $urandom;
		sel = int'($urandom_range(0, 3));
		w = r1;
		case (kind)
			0:
			begin
				op = (sel == 0) ? decode_pkg::op_addi
					: (sel == 1) ? decode_pkg::op_addis
					: (sel == 2) ? decode_pkg::op_ori : decode_pkg::op_lwz;
				w = d_word(op, r1[4:0], r1[9:5], r2[15:0]);
			end
			1:
			begin
				op = (sel == 1) ? decode_pkg::op_ds_ld : decode_pkg::op_ds_std;
				if (sel == 0)
					w = dq_word(r1[4:0], r1[9:5], r2[11:0], r2[15:12]);
				else
					// now and then a reserved ds xo value
					w = ds_word(op, r1[4:0], r1[9:5], r2[13:0], r2[31] ? r2[30:29] : 2'b00);
			end
			2:
			begin
				xo9 = (sel == 0) ? decode_pkg::xo_add
					: (sel == 1) ? decode_pkg::xo_subf
					: (sel == 2) ? decode_pkg::xo_mullw : decode_pkg::xo_divw;
				if (r2[31])
					w = x_word(r1[4:0], r1[9:5], r1[14:10], r2[9:0], r2[10]);
				else
					w = xo_word(r1[4:0], r1[9:5], r1[14:10], r2[11], xo9, r2[10]);
			end
			3:
			begin
				w = md_word(r1[4:0], r1[9:5], r2[5:0], r2[11:6], r2[14:12], r2[15]);
			end
			default:
			begin
				// raw word, mostly unknown opcodes
				w = r1;
			end
		endcase
		return w;
	endfunction

	task automatic drive_slot(input logic valid, input logic [31:0] word);
		logic [63:0] addr;
		addr = {$urandom, $urandom};
		addr[1:0] = 2'b00;
		@(negedge clock_i);
		fetch_i.valid = valid;
		fetch_i.address = addr;
		fetch_i.instr.raw = word;
		if (valid)
		begin
			exp_q.push_back(decode_ref(fetch_i));
			stamp_q.push_back(cycle_count);
		end
	endtask

	task automatic drain_pipeline();
		while (exp_q.size() != 0)
			drive_slot(1'b0, $urandom);
	endtask

	task automatic run_stream(input string name, input int kind, input int slots,
		input int gap_pct);
		int errors_before;
		int k;
		logic v;
		errors_before = error_count;
		for (int i = 0; i < slots; i++)
		begin
			k = (kind == kind_mixed) ? int'($urandom_range(0, 4)) : kind;
			v = (int'($urandom_range(0, 99)) >= gap_pct);
			drive_slot(v, random_word(k));
		end
		drain_pipeline();
		$display("test %s slots %0d errors %0d", name, slots, error_count - errors_before);
	endtask

	initial
	begin
		clock_i = 1'b0;
		arst_n_i = 1'b0;
		fetch_i = '0;
		error_count = 0;
		check_count = 0;
		void'($urandom(33684));
		repeat (reset_cycles) @(negedge clock_i);
		arst_n_i = 1'b1;

		run_stream("idle", 0, n_idle, 100);
		run_stream("d_forms", 0, n_d, 0);
		run_stream("dq_ds", 1, n_mem, 0);
		run_stream("x_xo", 2, n_ext, 0);
		run_stream("md", 3, n_md, 0);
		run_stream("mixed", kind_mixed, n_mix, 12);

		$display("checks %0d errors %0d", check_count, error_count);
		if (error_count == 0 && exp_q.size() == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input wire clock_i,
	input wire arst_n_i,
	input wire decode_pkg::fetch_t fetch_i,
	output decode_pkg::decoded_t decoded_o
);

	// first stage results, one cycle after fetch
	decode_pkg::imm_dec_t imm_dec;
	decode_pkg::reg_dec_t reg_dec;

	////////////////////////////////////////
	// stage 1, parallel format decoders
	////////////////////////////////////////
	decode_imm_forms u_imm_forms (
		.clock_i (clock_i),
		.arst_n_i (arst_n_i),
		.fetch_i (fetch_i),
		.imm_dec_o (imm_dec)
	);

	decode_reg_forms u_reg_forms (
		.clock_i (clock_i),
		.arst_n_i (arst_n_i),
		.fetch_i (fetch_i),
		.reg_dec_o (reg_dec)
	);

	////////////////////////////////////////
	// stage 2, format select and shaping
	////////////////////////////////////////
	decode_format_mux u_format_mux (
		.clock_i (clock_i),
		.arst_n_i (arst_n_i),
		.imm_dec_i (imm_dec),
		.reg_dec_i (reg_dec),
		.decoded_o (decoded_o)
	);

endmodule

`default_nettype wire

/* src/decode_format_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_format_mux (
	input wire clock_i,
	input wire arst_n_i,
	input wire decode_pkg::imm_dec_t imm_dec_i,
	input wire decode_pkg::reg_dec_t reg_dec_i,
	output decode_pkg::decoded_t decoded_o
);

	decode_pkg::decoded_t decoded_d;
	logic [decode_pkg::imm_width-1:0] d_ext;

	// d form extension before the byte shift
	assign d_ext = imm_dec_i.imm_unsigned ? {48'b0, imm_dec_i.raw_imm}
		: {{48{imm_dec_i.raw_imm[15]}}, imm_dec_i.raw_imm};

	always_comb
	begin
		decoded_d = '0;
		decoded_d.valid = imm_dec_i.valid;
		decoded_d.address = imm_dec_i.address;
		decoded_d.opcode = imm_dec_i.opcode;
		decoded_d.format = decode_pkg::fmt_invalid;
		decoded_d.fu = decode_pkg::fu_none;

		////////////////////////////////////////
		// immediate forms
		////////////////////////////////////////
		if (imm_dec_i.d_hit || imm_dec_i.dq_hit || imm_dec_i.ds_hit)
		begin
			decoded_d.reg1 = imm_dec_i.reg1;
			decoded_d.reg2 = imm_dec_i.reg2;
			decoded_d.reg1_use = imm_dec_i.reg1_use;
			decoded_d.reg2_use = imm_dec_i.reg2_use;
			decoded_d.reg1_en = 1'b1;
			decoded_d.reg2_en = 1'b1;
			decoded_d.imm_en = 1'b1;
			decoded_d.fu = imm_dec_i.fu;
			decoded_d.ra_or_zero = imm_dec_i.ra_or_zero;
		end
		else if (reg_dec_i.x_hit || reg_dec_i.md_hit || reg_dec_i.xo_hit)
		begin
			decoded_d.reg1 = reg_dec_i.reg1;
			decoded_d.reg2 = reg_dec_i.reg2;
			decoded_d.reg3 = reg_dec_i.reg3;
			decoded_d.reg1_use = reg_dec_i.reg1_use;
			decoded_d.reg2_use = reg_dec_i.reg2_use;
			decoded_d.reg3_use = reg_dec_i.reg3_use;
			decoded_d.reg1_en = 1'b1;
			decoded_d.reg2_en = 1'b1;
			decoded_d.reg3_en = 1'b1;
			decoded_d.bit1 = reg_dec_i.bit1;
			decoded_d.bit1_en = 1'b1;
			decoded_d.fu = reg_dec_i.fu;
			decoded_d.ra_or_zero = reg_dec_i.ra_or_zero;
		end

		// priority d, dq, ds, x, md, xo
		if (imm_dec_i.d_hit)
		begin
			decoded_d.format = decode_pkg::fmt_d;
			decoded_d.imm = d_ext << {imm_dec_i.shift_bytes, 3'b000};
		end
		else if (imm_dec_i.dq_hit)
		begin
			decoded_d.format = decode_pkg::fmt_dq;
			decoded_d.imm = {{48{imm_dec_i.raw_imm[11]}}, imm_dec_i.raw_imm[11:0], 4'b0000};
			decoded_d.ra_or_zero = 1'b1;
			decoded_d.bit1 = imm_dec_i.dq_bit;
			decoded_d.bit1_en = 1'b1;
		end
		else if (imm_dec_i.ds_hit)
		begin
			decoded_d.format = decode_pkg::fmt_ds;
			decoded_d.imm = {{48{imm_dec_i.raw_imm[13]}}, imm_dec_i.raw_imm[13:0], 2'b00};
		end
		////////////////////////////////////////
		// register forms
		////////////////////////////////////////
		else if (reg_dec_i.x_hit)
		begin
			decoded_d.format = decode_pkg::fmt_x;
			decoded_d.xopcode = reg_dec_i.xopcode;
			decoded_d.xopcode_en = 1'b1;
		end
		else if (reg_dec_i.md_hit)
		begin
			decoded_d.format = decode_pkg::fmt_md;
			decoded_d.reg3_is_imm = 1'b1;
			decoded_d.imm = {{(decode_pkg::imm_width-6){1'b0}}, reg_dec_i.sh};
			decoded_d.imm_en = 1'b1;
			decoded_d.bit2 = reg_dec_i.bit2;
			decoded_d.bit2_en = 1'b1;
		end
		else if (reg_dec_i.xo_hit)
		begin
			decoded_d.format = decode_pkg::fmt_xo;
			decoded_d.xopcode = reg_dec_i.xopcode;
			decoded_d.xopcode_en = 1'b1;
			decoded_d.ra_or_zero = 1'b0;
			decoded_d.bit2 = reg_dec_i.bit2;
			decoded_d.bit2_en = 1'b1;
		end
	end

	always_ff @(posedge clock_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			decoded_o.valid <= 1'b0;
			decoded_o.imm_en <= 1'b0;
			decoded_o.reg1_en <= 1'b0;
			decoded_o.reg2_en <= 1'b0;
			decoded_o.reg3_en <= 1'b0;
			decoded_o.reg3_is_imm <= 1'b0;
			decoded_o.bit1_en <= 1'b0;
			decoded_o.bit2_en <= 1'b0;
			decoded_o.xopcode_en <= 1'b0;
		end
		else
		begin
			decoded_o <= decoded_d;
		end
	end

endmodule

`default_nettype wire

/* src/decode_reg_forms.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_reg_forms (
	input wire clock_i,
	input wire arst_n_i,
	input wire decode_pkg::fetch_t fetch_i,
	output decode_pkg::reg_dec_t reg_dec_o
);

	decode_pkg::reg_dec_t reg_dec_d;

	always_comb
	begin
		reg_dec_d = '0;
		reg_dec_d.fu = decode_pkg::fu_none;
		// x and xo share the rt, ra, rb positions
		reg_dec_d.reg1 = fetch_i.instr.x.rt;
		reg_dec_d.reg2 = fetch_i.instr.x.ra;
		reg_dec_d.reg3 = fetch_i.instr.x.rb;
		reg_dec_d.reg1_use = decode_pkg::reg_write;
		reg_dec_d.reg2_use = decode_pkg::reg_read;
		reg_dec_d.reg3_use = decode_pkg::reg_read;

		if (fetch_i.valid)
		begin
			if (fetch_i.instr.x.opcode == decode_pkg::op_ext)
			begin
				////////////////////////////////////////
				// x / xo split on the 9 bit xo
				////////////////////////////////////////
				case (fetch_i.instr.xo.xo)
					decode_pkg::xo_add, decode_pkg::xo_subf:
					begin
						reg_dec_d.xo_hit = 1'b1;
						reg_dec_d.fu = decode_pkg::fu_alu;
					end
					decode_pkg::xo_mullw:
					begin
						reg_dec_d.xo_hit = 1'b1;
						reg_dec_d.fu = decode_pkg::fu_mul;
					end
					decode_pkg::xo_divw:
					begin
						reg_dec_d.xo_hit = 1'b1;
						reg_dec_d.fu = decode_pkg::fu_div;
					end
					default:
					begin
						reg_dec_d.x_hit = 1'b1;
						reg_dec_d.fu = decode_pkg::fu_logic;
					end
				endcase

				if (reg_dec_d.xo_hit)
				begin
					reg_dec_d.xopcode = {1'b0, fetch_i.instr.xo.xo};
					reg_dec_d.bit1 = fetch_i.instr.xo.oe;
					reg_dec_d.bit2 = fetch_i.instr.xo.rc;
				end
				else
				begin
					// oe position is part of the 10 bit x opcode
					reg_dec_d.xopcode = fetch_i.instr.x.xo;
					reg_dec_d.bit1 = fetch_i.instr.x.rc;
				end
			end
			else if (fetch_i.instr.md.opcode == decode_pkg::op_md)
			begin
				////////////////////////////////////////
				// md rotate forms
				////////////////////////////////////////
				reg_dec_d.md_hit = 1'b1;
				reg_dec_d.fu = decode_pkg::fu_alu;
				reg_dec_d.reg1 = fetch_i.instr.md.rs;
				reg_dec_d.reg2 = fetch_i.instr.md.ra;
				reg_dec_d.reg1_use = decode_pkg::reg_read;
				reg_dec_d.reg2_use = decode_pkg::reg_write;
				// third slot carries the shift, not a register
				reg_dec_d.reg3 = fetch_i.instr.md.sh_lo;
				reg_dec_d.reg3_use = decode_pkg::reg_unused;
				reg_dec_d.sh = {fetch_i.instr.md.sh_hi, fetch_i.instr.md.sh_lo};
				reg_dec_d.bit1 = fetch_i.instr.md.rc;
				reg_dec_d.bit2 = fetch_i.instr.md.sh_hi;
			end
		end
	end

	always_ff @(posedge clock_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			reg_dec_o.x_hit <= 1'b0;
			reg_dec_o.xo_hit <= 1'b0;
			reg_dec_o.md_hit <= 1'b0;
		end
		else
		begin
			reg_dec_o <= reg_dec_d;
		end
	end

endmodule

`default_nettype wire

/* src/decode_imm_forms.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_imm_forms (
	input wire clock_i,
	input wire arst_n_i,
	input wire decode_pkg::fetch_t fetch_i,
	output decode_pkg::imm_dec_t imm_dec_o
);

	decode_pkg::imm_dec_t imm_dec_d;

	always_comb
	begin
		imm_dec_d = '0;
		imm_dec_d.valid = fetch_i.valid;
		imm_dec_d.address = fetch_i.address;
		imm_dec_d.opcode = fetch_i.instr.d.opcode;
		imm_dec_d.fu = decode_pkg::fu_none;
		// common d layout register roles, rt written and ra read
		imm_dec_d.reg1 = fetch_i.instr.d.rt;
		imm_dec_d.reg2 = fetch_i.instr.d.ra;
		imm_dec_d.reg1_use = decode_pkg::reg_write;
		imm_dec_d.reg2_use = decode_pkg::reg_read;
		imm_dec_d.raw_imm = fetch_i.instr.d.d;

		if (fetch_i.valid)
		begin
			case (fetch_i.instr.d.opcode)
				decode_pkg::op_addi:
				begin
					imm_dec_d.d_hit = 1'b1;
					imm_dec_d.fu = decode_pkg::fu_alu;
					imm_dec_d.ra_or_zero = 1'b1;
				end
				decode_pkg::op_addis:
				begin
					imm_dec_d.d_hit = 1'b1;
					imm_dec_d.fu = decode_pkg::fu_alu;
					imm_dec_d.ra_or_zero = 1'b1;
					imm_dec_d.shift_bytes = 2'd2;
				end
				decode_pkg::op_ori:
				begin
					// rs is the source here, ra the target
					imm_dec_d.d_hit = 1'b1;
					imm_dec_d.fu = decode_pkg::fu_logic;
					imm_dec_d.imm_unsigned = 1'b1;
					imm_dec_d.reg1 = fetch_i.instr.d.ra;
					imm_dec_d.reg2 = fetch_i.instr.d.rt;
				end
				decode_pkg::op_lwz:
				begin
					imm_dec_d.d_hit = 1'b1;
					imm_dec_d.fu = decode_pkg::fu_ldst;
					imm_dec_d.ra_or_zero = 1'b1;
				end
				decode_pkg::op_lq:
				begin
					imm_dec_d.dq_hit = 1'b1;
					imm_dec_d.fu = decode_pkg::fu_ldst;
					imm_dec_d.ra_or_zero = 1'b1;
					imm_dec_d.raw_imm = {4'b0000, fetch_i.instr.dq.dq};
					// flag is the last bit of the low nibble
					imm_dec_d.dq_bit = fetch_i.instr.dq.low[0];
				end
				decode_pkg::op_ds_ld:
				begin
					if (fetch_i.instr.ds.xo == 2'b00)
					begin
						imm_dec_d.ds_hit = 1'b1;
						imm_dec_d.fu = decode_pkg::fu_ldst;
						imm_dec_d.ra_or_zero = 1'b1;
						imm_dec_d.raw_imm = {2'b00, fetch_i.instr.ds.ds};
					end
				end
				decode_pkg::op_ds_std:
				begin
					// store reads both registers
					if (fetch_i.instr.ds.xo == 2'b00)
					begin
						imm_dec_d.ds_hit = 1'b1;
						imm_dec_d.fu = decode_pkg::fu_ldst;
						imm_dec_d.reg1_use = decode_pkg::reg_read;
						imm_dec_d.raw_imm = {2'b00, fetch_i.instr.ds.ds};
					end
				end
				default:
				begin
					imm_dec_d.fu = decode_pkg::fu_none;
				end
			endcase
		end
	end

	always_ff @(posedge clock_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			imm_dec_o.valid <= 1'b0;
			imm_dec_o.d_hit <= 1'b0;
			imm_dec_o.dq_hit <= 1'b0;
			imm_dec_o.ds_hit <= 1'b0;
		end
		else
		begin
			imm_dec_o <= imm_dec_d;
		end
	end

endmodule

`default_nettype wire

/* src/decode_pkg.sv */
`default_nettype none

package decode_pkg;

	////////////////////////////////////////
	// isa widths
	////////////////////////////////////////
	localparam int instr_width = 32;
	localparam int addr_width = 64;
	localparam int reg_width = 5;
	localparam int imm_width = 64;
	localparam int xo_width = 10;
	localparam int opcode_width = 6;

	// primary opcodes
	localparam logic [opcode_width-1:0] op_addi = 6'd14;
	localparam logic [opcode_width-1:0] op_addis = 6'd15;
	localparam logic [opcode_width-1:0] op_ori = 6'd24;
	localparam logic [opcode_width-1:0] op_lwz = 6'd32;
	localparam logic [opcode_width-1:0] op_lq = 6'd56;
	localparam logic [opcode_width-1:0] op_ds_ld = 6'd58;
	localparam logic [opcode_width-1:0] op_ds_std = 6'd62;
	localparam logic [opcode_width-1:0] op_md = 6'd30;
	localparam logic [opcode_width-1:0] op_ext = 6'd31;

	// xo form extended opcodes, everything else under op_ext is x form
	localparam logic [8:0] xo_add = 9'd266;
	localparam logic [8:0] xo_subf = 9'd40;
	localparam logic [8:0] xo_mullw = 9'd235;
	localparam logic [8:0] xo_divw = 9'd491;

	typedef enum logic [4:0] {
		fmt_invalid = 5'd0,
		fmt_d = 5'd3,
		fmt_dq = 5'd4,
		fmt_ds = 5'd5,
		fmt_md = 5'd9,
		fmt_x = 5'd15,
		fmt_xo = 5'd19
	} format_e;

	typedef enum logic [2:0] {
		fu_alu = 3'd0,
		fu_ldst = 3'd1,
		fu_mul = 3'd2,
		fu_div = 3'd3,
		fu_logic = 3'd4,
		fu_none = 3'd5
	} fu_e;

	typedef enum logic [1:0] {
		reg_unused = 2'd0,
		reg_read = 2'd1,
		reg_write = 2'd2,
		reg_read_write = 2'd3
	} reg_use_e;

	////////////////////////////////////////
	// instruction word layouts, msb first
	////////////////////////////////////////
	typedef struct packed {
		logic [opcode_width-1:0] opcode;
		logic [reg_width-1:0] rt;
		logic [reg_width-1:0] ra;
		logic [15:0] d;
	} d_layout_t;

	typedef struct packed {
		logic [opcode_width-1:0] opcode;
		logic [reg_width-1:0] rt;
		logic [reg_width-1:0] ra;
		logic [11:0] dq;
		logic [3:0] low;
	} dq_layout_t;

	typedef struct packed {
		logic [opcode_width-1:0] opcode;
		logic [reg_width-1:0] rt;
		logic [reg_width-1:0] ra;
		logic [13:0] ds;
		logic [1:0] xo;
	} ds_layout_t;

	typedef struct packed {
		logic [opcode_width-1:0] opcode;
		logic [reg_width-1:0] rt;
		logic [reg_width-1:0] ra;
		logic [reg_width-1:0] rb;
		logic [xo_width-1:0] xo;
		logic rc;
	} x_layout_t;

	typedef struct packed {
		logic [opcode_width-1:0] opcode;
		logic [reg_width-1:0] rt;
		logic [reg_width-1:0] ra;
		logic [reg_width-1:0] rb;
		logic oe;
		logic [8:0] xo;
		logic rc;
	} xo_layout_t;

	typedef struct packed {
		logic [opcode_width-1:0] opcode;
		logic [reg_width-1:0] rs;
		logic [reg_width-1:0] ra;
		logic [4:0] sh_lo;
		logic [5:0] mb;
		logic [2:0] xo;
		logic sh_hi;
		logic rc;
	} md_layout_t;

	typedef union packed {
		logic [instr_width-1:0] raw;
		d_layout_t d;
		dq_layout_t dq;
		ds_layout_t ds;
		x_layout_t x;
		xo_layout_t xo;
		md_layout_t md;
	} instr_word_u;

	////////////////////////////////////////
	// stage buses
	////////////////////////////////////////
	typedef struct packed {
		logic valid;
		logic [addr_width-1:0] address;
		instr_word_u instr;
	} fetch_t;

	typedef struct packed {
		logic valid;
		logic d_hit;
		logic dq_hit;
		logic ds_hit;
		logic [reg_width-1:0] reg1;
		logic [reg_width-1:0] reg2;
		reg_use_e reg1_use;
		reg_use_e reg2_use;
		logic [15:0] raw_imm;
		logic imm_unsigned;
		logic [1:0] shift_bytes;
		logic ra_or_zero;
		logic dq_bit;
		fu_e fu;
		logic [addr_width-1:0] address;
		logic [opcode_width-1:0] opcode;
	} imm_dec_t;

	typedef struct packed {
		logic x_hit;
		logic xo_hit;
		logic md_hit;
		logic [reg_width-1:0] reg1;
		logic [reg_width-1:0] reg2;
		logic [reg_width-1:0] reg3;
		reg_use_e reg1_use;
		reg_use_e reg2_use;
		reg_use_e reg3_use;
		logic [xo_width-1:0] xopcode;
		logic bit1;
		logic bit2;
		logic [5:0] sh;
		logic ra_or_zero;
		fu_e fu;
	} reg_dec_t;

	typedef struct packed {
		logic valid;
		logic [addr_width-1:0] address;
		logic [opcode_width-1:0] opcode;
		format_e format;
		logic [imm_width-1:0] imm;
		logic imm_en;
		logic [reg_width-1:0] reg1;
		logic [reg_width-1:0] reg2;
		logic [reg_width-1:0] reg3;
		reg_use_e reg1_use;
		reg_use_e reg2_use;
		reg_use_e reg3_use;
		logic reg1_en;
		logic reg2_en;
		logic reg3_en;
		logic reg3_is_imm;
		logic bit1;
		logic bit2;
		logic bit1_en;
		logic bit2_en;
		logic ra_or_zero;
		logic [xo_width-1:0] xopcode;
		logic xopcode_en;
		fu_e fu;
	} decoded_t;

endpackage

`default_nettype wire
